/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = layer_mux_net_tb
FILELIST  = layer_mux_net.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* common/nn_pkg.sv */
//////////////////////////////////////////////////////////////////////
// nn_pkg
// sizes, weight word layout and layer masks of the neuron engine
//////////////////////////////////////////////////////////////////////
package nn_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    // physical neurons, reused for every logical layer
    localparam int num_neuron  = 4;
    // unsigned activation width
    localparam int input_size  = 8;
    // signed weight width
    localparam int weight_size = 8;
    localparam int layer_max   = 3;
    localparam int layer_bits  = 2;
    // wide enough for num_neuron full-scale products
    localparam int acc_size    = 20;
    // fixed point shift after relu
    localparam int frac_bits   = 4;
    // index of the input being accumulated
    localparam int sel_bits    = $clog2(num_neuron);

    // input aggregator state codes
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_fetch = 2'd1;
    localparam logic [1:0] st_start = 2'd2;
    localparam logic [1:0] st_wait  = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic signed [weight_size-1:0] weight_t;
    // element k multiplies input k
    typedef weight_t [num_neuron-1:0] weight_row_t;

    // flat for the rom, rows for the neurons
    typedef union packed {
        logic [num_neuron*num_neuron*weight_size-1:0] flat;
        weight_row_t [num_neuron-1:0]                  row;
    } weight_word_u;

    typedef logic [num_neuron-1:0][input_size-1:0] act_vec_t;

    // active neurons per layer, entry 0 is the first layer
    localparam logic [layer_max-1:0][num_neuron-1:0] layer_active_mask =
        {4'b0011, 4'b0111, 4'b1111};

endpackage

/* input_aggregator/input_aggregator.sv */
//////////////////////////////////////////////////////////////////////
// input_aggregator
// sequences the layers, feeds the neuron layer, holds the final result
//////////////////////////////////////////////////////////////////////
module input_aggregator
    import nn_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  act_vec_t              start_input,
    input  act_vec_t              agg_output,
    input  logic [num_neuron-1:0] agg_valid,
    output logic [layer_bits-1:0] rom_addr,
    input  weight_word_u          rom_data,
    output act_vec_t              layer_inputs,
    output weight_word_u          layer_weights,
    output logic [num_neuron-1:0] active,
    output logic                  layer_start,
    output logic                  busy,
    output act_vec_t              final_output,
    output logic                  final_output_valid
);

    logic [1:0]            state;
    logic [layer_bits-1:0] layer;
    logic                  accept;
    logic                  layer_done;
    logic                  last_layer;

    // start only counts while idle
    assign accept     = (state == st_idle) && start;
    assign last_layer = (layer == layer_bits'(layer_max - 1));

    // flags are still stale during the layer_start cycle itself,
    // they clear on the edge that ends it
    assign layer_done = (state == st_wait) && !layer_start &&
                        ((agg_valid & active) == active);

    assign rom_addr = layer;
    assign busy     = (state != st_idle);

    //////////////////////////////////////////////////////////////////////
    // layer sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= st_idle;
            layer              <= '0;
            layer_start        <= 1'b0;
            final_output_valid <= 1'b0;
        end else begin
            // single cycle pulse by default
            layer_start <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state              <= st_fetch;
                        layer              <= '0;
                        final_output_valid <= 1'b0;
                    end
                end
                // rom address is the layer index, data next cycle
                st_fetch: begin
                    state <= st_start;
                end
                st_start: begin
                    layer_start <= 1'b1;
                    state       <= st_wait;
                end
                st_wait: begin
                    if (layer_done) begin
                        if (last_layer) begin
                            final_output_valid <= 1'b1;
                            state              <= st_idle;
                        end else begin
                            layer <= layer + 1'b1;
                            state <= st_fetch;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // operand and result registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // outside vector taken on accept, so later start pulses cannot disturb it
        if (accept) begin
            layer_inputs <= start_input;
            final_output <= '0;
        end
        // operands settle in the same edge that raises layer_start
        if (state == st_start) begin
            if (layer != '0) begin
                layer_inputs <= agg_output;
            end
            layer_weights <= rom_data;
            active        <= layer_active_mask[layer];
        end
        if (layer_done && last_layer) begin
            final_output <= agg_output;
        end
    end

endmodule

/* layer_mux_net.f */
common/nn_pkg.sv
rtl/weight_rom.sv
input_aggregator/input_aggregator.sv
rtl/neuron.sv
rtl/neuron_layer.sv
rtl/output_aggregator.sv
rtl/layer_mux_net.sv
testbench/tb_clock_gen.sv
testbench/layer_mux_net_assert.sv
testbench/layer_mux_net_tb.sv

/* rtl/layer_mux_net.sv */
//////////////////////////////////////////////////////////////////////
// layer_mux_net
// layer-multiplexed inference engine, top level
//////////////////////////////////////////////////////////////////////
module layer_mux_net
    import nn_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  act_vec_t start_input,
    output logic     busy,
    output act_vec_t final_output,
    output logic     final_output_valid
);

    logic [layer_bits-1:0] rom_addr;
    weight_word_u          rom_data;
    act_vec_t              layer_inputs;
    weight_word_u          layer_weights;
    logic [num_neuron-1:0] active;
    logic                  layer_start;
    act_vec_t              result;
    logic [num_neuron-1:0] result_valid;
    act_vec_t              agg_output;
    logic [num_neuron-1:0] agg_valid;

    weight_rom u_weight_rom (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_data)
    );

    // producer
    input_aggregator u_input_aggregator (
        .clk                (clk),
        .rst                (rst),
        .start              (start),
        .start_input        (start_input),
        .agg_output         (agg_output),
        .agg_valid          (agg_valid),
        .rom_addr           (rom_addr),
        .rom_data           (rom_data),
        .layer_inputs       (layer_inputs),
        .layer_weights      (layer_weights),
        .active             (active),
        .layer_start        (layer_start),
        .busy               (busy),
        .final_output       (final_output),
        .final_output_valid (final_output_valid)
    );

    // consumer
    neuron_layer u_neuron_layer (
        .clk           (clk),
        .rst           (rst),
        .layer_start   (layer_start),
        .layer_inputs  (layer_inputs),
        .layer_weights (layer_weights),
        .active        (active),
        .result        (result),
        .result_valid  (result_valid)
    );

    // buffer between the two, closes the loop
    output_aggregator u_output_aggregator (
        .clk          (clk),
        .rst          (rst),
        .layer_start  (layer_start),
        .result       (result),
        .result_valid (result_valid),
        .agg_output   (agg_output),
        .agg_valid    (agg_valid)
    );

endmodule

/* rtl/neuron.sv */
//////////////////////////////////////////////////////////////////////
// neuron
// serial multiply-accumulate with relu, scaling and saturation
//////////////////////////////////////////////////////////////////////
module neuron
    import nn_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  layer_start,
    input  logic                  enable,
    input  act_vec_t              inputs,
    input  weight_row_t           weights,
    output logic [input_size-1:0] result,
    output logic                  result_valid
);

    logic signed [acc_size-1:0] acc;
    logic signed [acc_size-1:0] term;
    logic signed [acc_size-1:0] scaled;
    logic signed [input_size:0] in_ext;
    logic [input_size-1:0]      relu_sat;
    logic [sel_bits-1:0]        sel;
    logic                       run;
    logic                       acc_done;

    // sel rests at 0 between layers, so input 0 goes in on the layer_start edge
    assign in_ext = {1'b0, inputs[sel]};
    assign term   = in_ext * weights[sel];

    // relu, then shift, then clamp to the activation range
    always_comb begin
        scaled = acc >>> frac_bits;
        if (!enable || acc < 0) begin
            relu_sat = '0;
        end else if (scaled > (2 ** input_size) - 1) begin
            relu_sat = '1;
        end else begin
            relu_sat = scaled[input_size-1:0];
        end
    end

    // step control, valid num_neuron + 1 cycles after layer_start
    always_ff @(posedge clk) begin
        if (rst) begin
            run          <= 1'b0;
            acc_done     <= 1'b0;
            sel          <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (layer_start) begin
                run      <= 1'b1;
                acc_done <= 1'b0;
                sel      <= sel_bits'(1);
            end else if (run && !acc_done) begin
                // last input accumulated when sel wraps
                if (sel == sel_bits'(num_neuron - 1)) begin
                    acc_done <= 1'b1;
                end
                sel <= sel + 1'b1;
            end else if (run) begin
                run          <= 1'b0;
                result_valid <= 1'b1;
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (layer_start) begin
            acc <= term;
        end else if (run && !acc_done) begin
            acc <= acc + term;
        end
        if (run && acc_done) begin
            result <= relu_sat;
        end
    end

endmodule

/* rtl/neuron_layer.sv */
//////////////////////////////////////////////////////////////////////
// neuron_layer
// the physical neurons, sharing one input vector
//////////////////////////////////////////////////////////////////////
module neuron_layer
    import nn_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  layer_start,
    input  act_vec_t              layer_inputs,
    input  weight_word_u          layer_weights,
    input  logic [num_neuron-1:0] active,
    output act_vec_t              result,
    output logic [num_neuron-1:0] result_valid
);

    // row n of the weight word belongs to neuron n
    for (genvar n = 0; n < num_neuron; n++) begin : g_neuron
        neuron u_neuron (
            .clk          (clk),
            .rst          (rst),
            .layer_start  (layer_start),
            .enable       (active[n]),
            .inputs       (layer_inputs),
            .weights      (layer_weights.row[n]),
            .result       (result[n]),
            .result_valid (result_valid[n])
        );
    end

endmodule

/* rtl/output_aggregator.sv */
//////////////////////////////////////////////////////////////////////
// output_aggregator
// buffers per-neuron results until the next layer starts
//////////////////////////////////////////////////////////////////////
module output_aggregator
    import nn_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  layer_start,
    input  act_vec_t              result,
    input  logic [num_neuron-1:0] result_valid,
    output act_vec_t              agg_output,
    output logic [num_neuron-1:0] agg_valid
);

    // flags, set per neuron and dropped as a new layer begins
    always_ff @(posedge clk) begin
        if (rst) begin
            agg_valid <= '0;
        end else if (layer_start) begin
            agg_valid <= '0;
        end else begin
            agg_valid <= agg_valid | result_valid;
        end
    end

    // each slot only written by its own neuron
    always_ff @(posedge clk) begin
        for (int n = 0; n < num_neuron; n++) begin
            if (result_valid[n]) begin
                agg_output[n] <= result[n];
            end
        end
    end

endmodule

/* rtl/weight_rom.sv */
//////////////////////////////////////////////////////////////////////
// weight_rom
// one weight word per layer, registered read
//////////////////////////////////////////////////////////////////////
module weight_rom
    import nn_pkg::*;
(
    input  logic                  clk,
    input  logic [layer_bits-1:0] addr,
    output weight_word_u          data
);

    // contents fixed at build time
    logic [num_neuron*num_neuron*weight_size-1:0] mem [0:layer_max-1];

    initial begin
        $readmemh("weights.mem", mem);
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        data.flat <= mem[addr];
    end

endmodule

/* testbench/layer_mux_net_assert.sv */
//////////////////////////////////////////////////////////////////////
// layer_mux_net_assert
// handshake properties of the inference engine
//////////////////////////////////////////////////////////////////////
module layer_mux_net_assert (
    input logic clk,
    input logic rst,
    input logic start,
    input logic busy,
    input logic layer_start,
    input logic final_output_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // layer_start is a single cycle pulse
    single_layer_start: assert property (@(posedge clk) disable iff (rst)
        layer_start |=> !layer_start)
        else $error("layer_start stayed high for more than one cycle");

    // a finished result means the engine is idle
    valid_when_idle: assert property (@(posedge clk) disable iff (rst)
        final_output_valid |-> !busy)
        else $error("final_output_valid high while busy");

    // busy only rises after a start was seen
    busy_needs_start: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(start))
        else $error("busy rose without a start");

endmodule

bind layer_mux_net layer_mux_net_assert assert_i (
    .clk                (clk),
    .rst                (rst),
    .start              (start),
    .busy               (busy),
    .layer_start        (layer_start),
    .final_output_valid (final_output_valid)
);

/* testbench/layer_mux_net_tb.sv */
//////////////////////////////////////////////////////////////////////
// layer_mux_net_tb
// table driven check of the inference engine against a reference model
//////////////////////////////////////////////////////////////////////
module layer_mux_net_tb
    import nn_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int word_bits       = num_neuron * num_neuron * weight_size;
    localparam int num_entries     = 8;
    // entry that sees a second start while busy
    localparam int busy_entry      = 3;
    localparam int watchdog_cycles = (num_entries + 2) * 200;

    logic     clk;
    logic     rst;
    logic     start;
    act_vec_t start_input;
    logic     busy;
    act_vec_t final_output;
    logic     final_output_valid;

    // own copy of the weights, flat words
    logic [word_bits-1:0] ref_weights [0:layer_max-1];
    act_vec_t             stim_in  [num_entries];
    act_vec_t             stim_exp [num_entries];
    int                   rise_count = 0;

    tb_clock_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    layer_mux_net dut_i (
        .clk                (clk),
        .rst                (rst),
        .start              (start),
        .start_input        (start_input),
        .busy               (busy),
        .final_output       (final_output),
        .final_output_valid (final_output_valid)
    );

    // completions seen, one per rise
    always @(posedge final_output_valid) begin
        rise_count++;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model and helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // one logical layer, integer arithmetic
    function automatic act_vec_t model_layer(input act_vec_t in_vec,
                                             input logic [word_bits-1:0] word,
                                             input logic [num_neuron-1:0] mask);
        act_vec_t                      out_vec;
        logic signed [weight_size-1:0] w8;
        int                            sum;
        int                            scaled;
        for (int n = 0; n < num_neuron; n++) begin
            sum = 0;
            for (int k = 0; k < num_neuron; k++) begin
                // row n, element k
                w8  = word[(n * num_neuron + k) * weight_size +: weight_size];
                sum = sum + int'(in_vec[k]) * int'(w8);
            end
            if (!mask[n] || sum < 0) begin
                out_vec[n] = '0;
            end else begin
                scaled = sum / (2 ** frac_bits);
                if (scaled > (2 ** input_size) - 1) begin
                    out_vec[n] = '1;
                end else begin
                    out_vec[n] = scaled[input_size-1:0];
                end
            end
        end
        return out_vec;
    endfunction

    function automatic act_vec_t model_net(input act_vec_t in_vec);
        act_vec_t vec;
        vec = in_vec;
        for (int l = 0; l < layer_max; l++) begin
            vec = model_layer(vec, ref_weights[l], layer_active_mask[l]);
        end
        return vec;
    endfunction

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic compare_act(input string what, input act_vec_t got, input act_vec_t exp);
        if (got !== exp) begin
            $display("** Error (%0d ns): %s, expected %h, got %h", $time, what, exp, got);
            abort_run();
        end
    endtask

    task automatic compare_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error (%0d ns): %s, expected %b, got %b", $time, what, exp, got);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rnd;
        act_vec_t    off_slots;

        start       = 1'b0;
        start_input = '0;

        $readmemh("weights.mem", ref_weights);

        // hand picked vectors
        stim_in[0] = '0;
        stim_in[1] = '1;
        stim_in[2] = {8'h80, 8'h01, 8'hc0, 8'h10};
        stim_in[6] = {8'h00, 8'hff, 8'h00, 8'hff};
        stim_in[7] = {8'h20, 8'h40, 8'h60, 8'h80};
        // pseudo random vectors, fixed seed
        rnd = 32'h6f975e73;
        for (int i = 3; i < 6; i++) begin
            rnd        = next_random(rnd);
            stim_in[i] = rnd;
        end
        for (int i = 0; i < num_entries; i++) begin
            stim_exp[i] = model_net(stim_in[i]);
        end

        // idle state after reset
        wait (rst === 1'b0);
        @(posedge clk);
        #1;
        compare_bit("busy after reset", busy, 1'b0);
        compare_bit("final_output_valid after reset", final_output_valid, 1'b0);
        repeat (4) begin
            @(posedge clk);
            #1;
            compare_bit("final_output_valid before first start", final_output_valid, 1'b0);
        end

        for (int i = 0; i < num_entries; i++) begin
            start       = 1'b1;
            start_input = stim_in[i];
            @(posedge clk);
            #1;
            start       = 1'b0;
            // vector must already be captured
            start_input = ~stim_in[i];
            compare_bit("busy after accepted start", busy, 1'b1);
            compare_bit("final_output_valid cleared by start", final_output_valid, 1'b0);
            compare_act("final_output cleared by start", final_output, '0);

            // start while busy, to be ignored
            if (i == busy_entry) begin
                repeat (3) begin
                    @(posedge clk);
                    #1;
                end
                start = 1'b1;
                @(posedge clk);
                #1;
                start = 1'b0;
            end

            while (final_output_valid !== 1'b1) begin
                @(posedge clk);
                #1;
            end

            // slots of neurons masked off in the last layer
            off_slots = final_output;
            for (int n = 0; n < num_neuron; n++) begin
                if (layer_active_mask[layer_max-1][n]) begin
                    off_slots[n] = '0;
                end
            end
            compare_act("disabled neuron slots", off_slots, '0);
            compare_act("final_output", final_output, stim_exp[i]);
            compare_bit("busy with final_output_valid", busy, 1'b0);
            compare_bit("one completion per accepted start", rise_count == i + 1, 1'b1);

            // even entries idle a while, odd ones go back to back
            if (i % 2 == 0) begin
                repeat (3) begin
                    @(posedge clk);
                    #1;
                    compare_bit("final_output_valid held", final_output_valid, 1'b1);
                    compare_act("final_output held", final_output, stim_exp[i]);
                end
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

    // watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles before all entries finished",
                 watchdog_cycles);
        abort_run();
    end

endmodule

/* testbench/tb_clock_gen.sv */
//////////////////////////////////////////////////////////////////////
// tb_clock_gen
// 10 ns clock and a two cycle synchronous reset
//////////////////////////////////////////////////////////////////////
module tb_clock_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period  = 5;
    localparam int reset_cycles = 2;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // held over two rising edges, dropped just after the second
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* weights.mem */
// one 128-bit word per layer; leading digits are row 3 element 3, last digits row 0 element 0
040404040808E0E0F010F01008102040
7F7F7F7FF0F018182010101010F02010
8080808011223344F020E04008080808
